/* compile.f */
+incdir+verilog
+incdir+tests
verilog/addrgen_pkg.sv
verilog/addrgen_ifs.sv
verilog/addrgen_cfg_regs.sv
verilog/addrgen_loop_counters.sv
verilog/addrgen_strobe_gen.sv
verilog/addrgen_progress.sv
verilog/addrgen_top.sv
tests/addrgen_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal --timescale 1ns/1ps -f compile.f \
       --top-module addrgen_tb -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vaddrgen_tb > sim.log 2>&1 \
  && grep -q "^Test passed$" sim.log \
  && echo "simulation PASS" \
  || { echo "simulation FAIL, see build.log and sim.log"; exit 1; }

/* tests/addrgen_model.svh */
/*
  reference model of the address generator loop nest
  included inside the testbench module: load_model on start, predict_outputs
  for the current word, advance_model after every step the DUT takes
*/
`ifndef ADDRGEN_MODEL_SVH
`define ADDRGEN_MODEL_SVH

// configuration as captured at start
addrgen_pkg::addr_t cfg_base;
addrgen_pkg::addr_t cfg_line_step;  // strides widened with their sign
addrgen_pkg::addr_t cfg_feat_step;
int                 cfg_words;      // words per line, one extra when misaligned
int                 cfg_lines;      // lines per feature
int                 cfg_roll;
logic               cfg_outer;
logic               cfg_misaligned;
int                 cfg_trans;

// loop position of the model
int                 word_idx;
int                 line_idx;
int                 feat_idx;
addrgen_pkg::addr_t word_off;
addrgen_pkg::addr_t line_off;
addrgen_pkg::addr_t feat_off;
int                 trans_cnt;      // counted words so far

// expected outputs for the current word
addrgen_pkg::addr_t exp_addr;
addrgen_pkg::strb_t exp_strb;
logic               exp_first;
logic               exp_last;
logic               exp_line_upd;   // line boundary if this word steps
logic               exp_feat_upd;

function automatic addrgen_pkg::addr_t widen_stride(input addrgen_pkg::stride_t s);
  return {{(`ADDRGEN_ADDR_W - `ADDRGEN_STRIDE_W){s[`ADDRGEN_STRIDE_W-1]}}, s};
endfunction

function automatic void load_model(
  input addrgen_pkg::addr_t   base,
  input addrgen_pkg::trans_t  trans,
  input addrgen_pkg::len_t    line_len,
  input addrgen_pkg::stride_t line_stride,
  input addrgen_pkg::len_t    feat_len,
  input addrgen_pkg::stride_t feat_stride,
  input addrgen_pkg::len_t    roll,
  input logic                 outer
);
  cfg_misaligned = (base[1:0] != 2'b00) || (line_stride[1:0] != 2'b00) ||
                   (feat_stride[1:0] != 2'b00);
  cfg_base       = base;
  cfg_line_step  = widen_stride(line_stride);
  cfg_feat_step  = widen_stride(feat_stride);
  cfg_words      = int'(line_len) + (cfg_misaligned ? 1 : 0);
  cfg_lines      = int'(feat_len);
  cfg_roll       = int'(roll);
  cfg_outer      = outer;
  cfg_trans      = int'(trans);
  word_idx       = 0;
  line_idx       = 0;
  feat_idx       = 0;
  word_off       = '0;
  line_off       = '0;
  feat_off       = '0;
  trans_cnt      = 0;
endfunction

function automatic void predict_outputs();
  addrgen_pkg::addr_t sum;
  int                 lane;
  sum       = cfg_base + feat_off + line_off + word_off;
  lane      = int'(sum[1:0]);  // byte where the data starts
  exp_addr  = sum & ~addrgen_pkg::addr_t'(3);
  exp_first = (word_idx == 0);
  exp_last  = (word_idx == cfg_words - 1);
  for (int b = 0; b < `ADDRGEN_STRB_W; b++) begin
    if (!cfg_misaligned) begin
      exp_strb[b] = 1'b1;
    end else if (exp_last) begin
      exp_strb[b] = (b < lane);   // trailing bytes only
    end else if (exp_first) begin
      exp_strb[b] = (b >= lane);  // leading bytes masked
    end else begin
      exp_strb[b] = 1'b1;
    end
  end
  exp_line_upd = exp_last;
  exp_feat_upd = exp_last && (line_idx == cfg_lines - 1);
endfunction

function automatic void advance_model();
  if (!(cfg_misaligned && word_idx == 0)) begin
    trans_cnt++;  // leading word of a misaligned line is free
  end
  if (word_idx < cfg_words - 1) begin
    word_idx++;
    word_off = word_off + addrgen_pkg::addr_t'(`ADDRGEN_STRB_W);
  end else if (line_idx < cfg_lines - 1) begin
    word_idx = 0;
    word_off = '0;
    line_idx++;
    line_off = line_off + cfg_line_step;
  end else begin
    word_idx = 0;
    word_off = '0;
    line_idx = 0;
    line_off = '0;
    if (cfg_outer) begin
      if (cfg_roll == 0 || feat_idx == cfg_roll - 1) begin
        feat_idx = 0;
        feat_off = feat_off + cfg_feat_step;
      end else begin
        feat_idx++;  // replay same feature offset
      end
    end else if (cfg_roll == 0 || feat_idx < cfg_roll - 1) begin
      feat_idx++;
      feat_off = feat_off + cfg_feat_step;
    end else begin
      feat_idx = 0;  // inner loop back to first feature
      feat_off = '0;
    end
  end
endfunction

function automatic bit model_done();
  return trans_cnt == cfg_trans;
endfunction

`endif

/* tests/addrgen_tb.sv */
/*
  testbench for the strided address generator
  draws 40 random configurations from an LFSR, runs each against the
  included loop model and checks every cycle
  some runs are cut short by a restart
*/
`timescale 1ns/1ps
`default_nettype none

`include "addrgen_cfg.svh"

module addrgen_tb;

  localparam int NUM_CFG     = 40;
  localparam int MAX_TRANS   = 63;
  localparam int LONGEST_RUN = 2 * MAX_TRANS;  // misaligned one-word lines count every other step
  localparam int CYCLE_LIMIT = NUM_CFG * (LONGEST_RUN * 2 + 20);

  logic                 clk_i;
  logic                 rst_ni;
  logic                 start_i;
  logic                 enable_i;
  addrgen_pkg::addr_t   base_addr_i;
  addrgen_pkg::trans_t  trans_size_i;
  addrgen_pkg::len_t    line_length_i;
  addrgen_pkg::stride_t line_stride_i;
  addrgen_pkg::len_t    feat_length_i;
  addrgen_pkg::stride_t feat_stride_i;
  addrgen_pkg::len_t    feat_roll_i;
  logic                 loop_outer_i;
  addrgen_pkg::addr_t   addr_o;
  addrgen_pkg::strb_t   strb_o;
  logic                 first_o;
  logic                 last_o;
  logic                 word_update_o;
  logic                 line_update_o;
  logic                 feat_update_o;
  logic                 busy_o;
  logic                 done_o;

  logic [31:0] lfsr_state = 32'h644f_a907;
  int unsigned cycle_cnt  = 0;
  string       test_name  = "reset";
  logic        run_open   = 1'b0;  // last run was cut before done

  `include "addrgen_model.svh"

  addrgen_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      abort_run("run hung: cycle limit reached before all configurations finished");
    end
  end

  // fibonacci lfsr x^32+x^22+x^2+x+1 shifted once per bit taken
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic draw_enable();
    return draw_bits(4) < 11;  // about 70 percent
  endfunction

  // word multiple in -128..124 where a quarter get a byte offset
  function automatic addrgen_pkg::stride_t draw_stride();
    logic [5:0]           b;
    addrgen_pkg::stride_t s;
    b = 6'(draw_bits(6));
    s = {{8{b[5]}}, b, 2'b00};
    if (draw_bits(2) == 0) begin
      s[1:0] = 2'(draw_bits(2));
    end
    return s;
  endfunction

  task automatic check_addr(input string what, input addrgen_pkg::addr_t exp,
                            input addrgen_pkg::addr_t act);
    if (exp !== act) begin
      abort_run($sformatf("FAILED %s %s: expected 0x%h, actual 0x%h", test_name, what, exp, act));
    end
  endtask

  task automatic check_strb(input string what, input addrgen_pkg::strb_t exp,
                            input addrgen_pkg::strb_t act);
    if (exp !== act) begin
      abort_run($sformatf("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      abort_run($sformatf("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  // outputs of the current word with flags set only when the loops step
  task automatic check_word(input logic stepping);
    predict_outputs();
    check_addr("addr", exp_addr, addr_o);
    check_strb("strb", exp_strb, strb_o);
    check_flag("first", exp_first, first_o);
    check_flag("last", exp_last, last_o);
    check_flag("word_update", stepping, word_update_o);
    check_flag("line_update", stepping & exp_line_upd, line_update_o);
    check_flag("feat_update", stepping & exp_feat_upd, feat_update_o);
  endtask

  // entered and left 1 ns after a rising edge
  task automatic run_config(input int idx);
    addrgen_pkg::addr_t   base;
    addrgen_pkg::trans_t  trans;
    addrgen_pkg::len_t    line_len;
    addrgen_pkg::len_t    feat_len;
    addrgen_pkg::len_t    roll;
    addrgen_pkg::stride_t line_stride;
    addrgen_pkg::stride_t feat_stride;
    logic                 outer;
    logic                 running;
    int                   cut_len;  // cycles until a restart or 0 to run to done
    int                   cycles;
    test_name   = $sformatf("cfg%0d", idx);
    line_len    = addrgen_pkg::len_t'(draw_bits(2) + 32'd1);
    feat_len    = addrgen_pkg::len_t'(draw_bits(2) + 32'd1);
    roll        = addrgen_pkg::len_t'(draw_bits(2));
    outer       = draw_bits(1) != 0;
    line_stride = draw_stride();
    feat_stride = draw_stride();
    base        = draw_bits(32);
    if (draw_bits(2) != 0) begin
      base[1:0] = 2'b00;
    end
    trans   = (idx == 3) ? '0 : addrgen_pkg::trans_t'(draw_bits(6));
    cut_len = (idx % 5 == 4) ? int'(draw_bits(4)) + 2 : 0;

    start_i       = 1'b1;
    enable_i      = 1'b0;  // old run holds during the start cycle
    base_addr_i   = base;
    trans_size_i  = trans;
    line_length_i = line_len;
    line_stride_i = line_stride;
    feat_length_i = feat_len;
    feat_stride_i = feat_stride;
    feat_roll_i   = roll;
    loop_outer_i  = outer;
    @(posedge clk_i);
    #1;
    // config is captured so the inputs may change
    start_i       = 1'b0;
    base_addr_i   = ~base;
    trans_size_i  = ~trans;
    line_length_i = ~line_len;
    line_stride_i = ~line_stride;
    feat_length_i = ~feat_len;
    feat_stride_i = ~feat_stride;
    feat_roll_i   = ~roll;
    loop_outer_i  = ~outer;
    enable_i      = draw_enable();
    load_model(base, trans, line_len, line_stride, feat_len, feat_stride, roll, outer);
    #2;
    check_flag("step while clearing", 1'b0, word_update_o);
    check_flag("busy before start takes effect", run_open, busy_o);
    @(posedge clk_i);
    #1;

    running = !model_done();
    cycles  = 0;
    while (running && (cut_len == 0 || cycles < cut_len)) begin
      enable_i = draw_enable();
      #2;
      check_flag("busy", 1'b1, busy_o);
      check_flag("done", 1'b0, done_o);
      check_word(enable_i);
      if (enable_i) begin
        advance_model();
      end
      running = !model_done();
      cycles++;
      @(posedge clk_i);
      #1;
    end

    if (!running) begin
      // enables have no effect once the run is complete
      repeat (3) begin
        enable_i = 1'b1;
        #2;
        check_flag("busy after end", 1'b0, busy_o);
        check_flag("done after end", 1'b1, done_o);
        check_word(1'b0);
        @(posedge clk_i);
        #1;
      end
    end
    run_open = running;
    enable_i = 1'b0;
  endtask

  initial begin
    rst_ni        = 1'b0;
    start_i       = 1'b0;
    enable_i      = 1'b0;
    base_addr_i   = '0;
    trans_size_i  = '0;
    line_length_i = '0;
    line_stride_i = '0;
    feat_length_i = '0;
    feat_stride_i = '0;
    feat_roll_i   = '0;
    loop_outer_i  = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // enable alone must not start anything after reset
    repeat (4) begin
      enable_i = 1'b1;
      #2;
      check_flag("busy", 1'b0, busy_o);
      check_flag("done", 1'b0, done_o);
      check_flag("word_update", 1'b0, word_update_o);
      check_flag("line_update", 1'b0, line_update_o);
      check_flag("feat_update", 1'b0, feat_update_o);
      @(posedge clk_i);
      #1;
    end
    enable_i = 1'b0;

    for (int i = 0; i < NUM_CFG; i++) begin
      run_config(i);
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/addrgen_cfg.svh */
/*
  width settings for the strided address generator
  included by the package and by any RTL that needs a raw width
*/
`ifndef ADDRGEN_CFG_SVH
`define ADDRGEN_CFG_SVH

// byte address width
`define ADDRGEN_ADDR_W 32

// word, line and feature index width
`define ADDRGEN_CNT_W 10

`define ADDRGEN_TRANS_W 16   // transaction counter
`define ADDRGEN_STRIDE_W 16  // strides and lengths

// bytes per word, also the fixed address step
`define ADDRGEN_STRB_W 4

`endif

/* verilog/addrgen_cfg_regs.sv */
/*
  configuration capture for the address generator
  samples all settings on start_i and turns raw lengths into loop limits
  also delays start_i by one cycle for the rest of the design
*/
`timescale 1ns/1ps
`default_nettype none

module addrgen_cfg_regs (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 start_i,
  input  wire addrgen_pkg::addr_t   base_addr_i,
  input  wire addrgen_pkg::trans_t  trans_size_i,
  input  wire addrgen_pkg::len_t    line_length_i,
  input  wire addrgen_pkg::stride_t line_stride_i,
  input  wire addrgen_pkg::len_t    feat_length_i,
  input  wire addrgen_pkg::stride_t feat_stride_i,
  input  wire addrgen_pkg::len_t    feat_roll_i,
  input  wire logic                 loop_outer_i,
  addrgen_cfg_if.drv                cfg
);

  logic              misaligned_d;  // from the raw inputs
  addrgen_pkg::len_t line_last_d;

  // any nonzero byte offset in base or strides
  assign misaligned_d = (base_addr_i[1:0] != 2'b00) |
                        (line_stride_i[1:0] != 2'b00) |
                        (feat_stride_i[1:0] != 2'b00);

  // misaligned lines need one extra word
  assign line_last_d = misaligned_d ? line_length_i
                                    : line_length_i - addrgen_pkg::len_t'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg.base_addr     <= '0;
      cfg.line_stride   <= '0;
      cfg.feat_stride   <= '0;
      cfg.line_last     <= '0;
      cfg.feat_len_last <= '0;
      cfg.roll_last     <= '0;
      cfg.roll_zero     <= 1'b1;
      cfg.loop_outer    <= 1'b0;
      cfg.misaligned    <= 1'b0;
      cfg.trans_size    <= '0;
    end else if (start_i) begin
      cfg.base_addr     <= base_addr_i;
      cfg.line_stride   <= line_stride_i;
      cfg.feat_stride   <= feat_stride_i;
      cfg.line_last     <= line_last_d;
      cfg.feat_len_last <= feat_length_i - addrgen_pkg::len_t'(1);
      cfg.roll_last     <= feat_roll_i - addrgen_pkg::len_t'(1);  // wraps when roll is 0
      cfg.roll_zero     <= (feat_roll_i == '0);
      cfg.loop_outer    <= loop_outer_i;
      cfg.misaligned    <= misaligned_d;
      cfg.trans_size    <= trans_size_i;
    end
  end

  // start seen by counters and FSM one cycle later, with the new config
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg.start <= 1'b0;
    end else begin
      cfg.start <= start_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/addrgen_ifs.sv */
/*
  internal buses of the address generator
  cfg bus carries the captured, pre-decoded configuration
  loop bus carries the step strobe and the loop offsets
*/
`timescale 1ns/1ps
`default_nettype none

interface addrgen_cfg_if;
  addrgen_pkg::addr_t   base_addr;
  addrgen_pkg::stride_t line_stride;
  addrgen_pkg::stride_t feat_stride;
  addrgen_pkg::len_t    line_last;      // last word index of a line
  addrgen_pkg::len_t    feat_len_last;  // last line index of a feature
  addrgen_pkg::len_t    roll_last;      // feat roll minus one
  logic                 roll_zero;
  logic                 loop_outer;
  logic                 misaligned;     // base or a stride not word aligned
  addrgen_pkg::trans_t  trans_size;
  logic                 start;          // registered start pulse

  modport drv (
    output base_addr, line_stride, feat_stride, line_last, feat_len_last,
           roll_last, roll_zero, loop_outer, misaligned, trans_size, start
  );

  modport rd (
    input base_addr, line_stride, feat_stride, line_last, feat_len_last,
          roll_last, roll_zero, loop_outer, misaligned, trans_size, start
  );
endinterface

interface addrgen_loop_if;
  logic               step;        // advance the loops this cycle
  addrgen_pkg::addr_t feat_off;
  addrgen_pkg::addr_t line_off;
  addrgen_pkg::addr_t word_off;
  logic               first_word;  // word index is zero
  logic               last_word;   // word index at line_last

  modport ctl (output step, input first_word);  // progress tracker
  modport cnt (
    input  step,
    output feat_off, line_off, word_off, first_word, last_word
  );
  modport rd (input feat_off, line_off, word_off, first_word, last_word);
endinterface

`default_nettype wire

/* verilog/addrgen_loop_counters.sv */
/*
  three nested loops of the address generator: words, lines, features
  each step moves one word; boundaries roll into the outer loops
  update flags tell which loop moved in the current step
*/
`timescale 1ns/1ps
`default_nettype none

`include "addrgen_cfg.svh"

module addrgen_loop_counters (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  addrgen_cfg_if.rd     cfg,
  addrgen_loop_if.cnt   loop,
  output logic          word_update_o,
  output logic          line_update_o,
  output logic          feat_update_o
);

  addrgen_pkg::cnt_t  word_idx;
  addrgen_pkg::cnt_t  line_idx;
  addrgen_pkg::cnt_t  feat_idx;
  addrgen_pkg::addr_t word_off;
  addrgen_pkg::addr_t line_off;
  addrgen_pkg::addr_t feat_off;

  logic word_more;  // still inside the line
  logic line_more;  // still inside the feature
  logic feat_wrap;  // outer mode, roll group complete
  logic feat_more;  // inner mode, more features before rolling back

  addrgen_pkg::addr_t line_step;  // sign extended strides
  addrgen_pkg::addr_t feat_step;

  assign word_more = addrgen_pkg::len_t'(word_idx) < cfg.line_last;
  assign line_more = addrgen_pkg::len_t'(line_idx) < cfg.feat_len_last;
  assign feat_wrap = (addrgen_pkg::len_t'(feat_idx) == cfg.roll_last) | cfg.roll_zero;
  assign feat_more = (addrgen_pkg::len_t'(feat_idx) < cfg.roll_last) | cfg.roll_zero;

  assign line_step = addrgen_pkg::addr_t'(cfg.line_stride);
  assign feat_step = addrgen_pkg::addr_t'(cfg.feat_stride);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_idx <= '0;
      line_idx <= '0;
      feat_idx <= '0;
      word_off <= '0;
      line_off <= '0;
      feat_off <= '0;
    end else if (cfg.start) begin  // new run
      word_idx <= '0;
      line_idx <= '0;
      feat_idx <= '0;
      word_off <= '0;
      line_off <= '0;
      feat_off <= '0;
    end else if (loop.step) begin
      if (word_more) begin
        word_idx <= word_idx + addrgen_pkg::cnt_t'(1);
        word_off <= word_off + addrgen_pkg::addr_t'(`ADDRGEN_STRB_W);
      end else if (line_more) begin  // next line
        word_idx <= '0;
        word_off <= '0;
        line_idx <= line_idx + addrgen_pkg::cnt_t'(1);
        line_off <= line_off + line_step;
      end else begin
        // feature boundary, lower loops restart
        word_idx <= '0;
        word_off <= '0;
        line_idx <= '0;
        line_off <= '0;
        if (cfg.loop_outer) begin
          if (feat_wrap) begin  // same offsets reused roll times, then move on
            feat_idx <= '0;
            feat_off <= feat_off + feat_step;
          end else begin
            feat_idx <= feat_idx + addrgen_pkg::cnt_t'(1);
          end
        end else if (feat_more) begin
          feat_idx <= feat_idx + addrgen_pkg::cnt_t'(1);
          feat_off <= feat_off + feat_step;
        end else begin  // inner loop rolls back to the first feature
          feat_idx <= '0;
          feat_off <= '0;
        end
      end
    end
  end

  assign loop.word_off   = word_off;
  assign loop.line_off   = line_off;
  assign loop.feat_off   = feat_off;
  assign loop.first_word = (word_idx == '0);
  assign loop.last_word  = (addrgen_pkg::len_t'(word_idx) == cfg.line_last);

  // which loop the current step advances
  assign word_update_o = loop.step;
  assign line_update_o = loop.step & ~word_more;
  assign feat_update_o = loop.step & ~word_more & ~line_more;

endmodule

`default_nettype wire

/* verilog/addrgen_pkg.sv */
/*
  shared types of the address generator
  refer to them as addrgen_pkg::name
*/
`default_nettype none

`include "addrgen_cfg.svh"

package addrgen_pkg;

  typedef logic [`ADDRGEN_ADDR_W-1:0] addr_t;     // byte address or offset
  typedef logic [`ADDRGEN_CNT_W-1:0] cnt_t;       // loop index
  typedef logic [`ADDRGEN_TRANS_W-1:0] trans_t;   // transaction count
  typedef logic [`ADDRGEN_STRIDE_W-1:0] len_t;    // length in words/lines/features

  // byte stride, sign extended when added to an offset
  typedef logic signed [`ADDRGEN_STRIDE_W-1:0] stride_t;

  typedef logic [`ADDRGEN_STRB_W-1:0] strb_t;     // byte enables

  // run state
  typedef enum logic [1:0] {
    RUN_IDLE = 2'd0,  // out of reset, nothing started
    RUN_BUSY = 2'd1,  // stepping on enable
    RUN_DONE = 2'd2   // trans count reached
  } run_state_e;

endpackage

`default_nettype wire

/* verilog/addrgen_progress.sv */
/*
  run control of the address generator
  idle until start, busy until trans_size words went out, then done
  only busy cycles with enable_i step the loops
*/
`timescale 1ns/1ps
`default_nettype none

module addrgen_progress (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     enable_i,
  addrgen_cfg_if.rd     cfg,
  addrgen_loop_if.ctl   loop,
  output logic          busy_o,
  output logic          done_o
);

  addrgen_pkg::run_state_e state_q, state_d;
  addrgen_pkg::trans_t     trans_cnt;
  addrgen_pkg::trans_t     trans_cnt_nxt;
  logic                    count_en;

  // the leading word of a misaligned line is not counted
  assign count_en      = loop.step & ~(cfg.misaligned & loop.first_word);
  assign trans_cnt_nxt = trans_cnt + addrgen_pkg::trans_t'(1);

  always_comb begin
    state_d = state_q;
    if (cfg.start) begin
      // empty run finishes at once
      state_d = (cfg.trans_size == '0) ? addrgen_pkg::RUN_DONE : addrgen_pkg::RUN_BUSY;
    end else begin
      case (state_q)
        addrgen_pkg::RUN_BUSY: begin
          if (count_en && (trans_cnt_nxt == cfg.trans_size)) begin
            state_d = addrgen_pkg::RUN_DONE;
          end
        end
        default: state_d = state_q;  // idle and done wait for start
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= addrgen_pkg::RUN_IDLE;
      trans_cnt <= '0;
    end else begin
      state_q <= state_d;
      if (cfg.start) begin
        trans_cnt <= '0;
      end else if (count_en) begin
        trans_cnt <= trans_cnt_nxt;
      end
    end
  end

  // no step while the counters clear
  assign loop.step = enable_i & (state_q == addrgen_pkg::RUN_BUSY) & ~cfg.start;

  assign busy_o = (state_q == addrgen_pkg::RUN_BUSY);
  assign done_o = (state_q == addrgen_pkg::RUN_DONE);

endmodule

`default_nettype wire

/* verilog/addrgen_strobe_gen.sv */
/*
  output address and byte strobe of the current word
  purely combinational on top of the loop offsets
*/
`timescale 1ns/1ps
`default_nettype none

`include "addrgen_cfg.svh"

module addrgen_strobe_gen (
  addrgen_cfg_if.rd           cfg,
  addrgen_loop_if.rd          loop,
  output addrgen_pkg::addr_t  addr_o,
  output addrgen_pkg::strb_t  strb_o
);

  addrgen_pkg::addr_t addr_sum;  // unaligned byte address
  logic [1:0]         byte_off;  // byte lane of addr_sum
  addrgen_pkg::strb_t lead_mask;

  assign addr_sum = cfg.base_addr + loop.feat_off + loop.line_off + loop.word_off;
  assign byte_off = addr_sum[1:0];

  // word aligned address
  assign addr_o = {addr_sum[`ADDRGEN_ADDR_W-1:2], 2'b00};

  // drops the bytes below the start offset
  assign lead_mask = addrgen_pkg::strb_t'('1) << byte_off;

  always_comb begin
    strb_o = '1;
    if (cfg.misaligned) begin
      if (loop.first_word) begin
        strb_o = lead_mask;
      end
      if (loop.last_word) begin
        strb_o = ~lead_mask;  // trailing bytes of the extra word
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/addrgen_top.sv */
/*
  strided address generator for a memory streaming unit
  pulse start_i with a configuration, then hold enable_i to get one
  word address and byte strobe per enabled cycle
*/
`timescale 1ns/1ps
`default_nettype none

module addrgen_top (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 start_i,
  input  wire logic                 enable_i,
  input  wire addrgen_pkg::addr_t   base_addr_i,
  input  wire addrgen_pkg::trans_t  trans_size_i,
  input  wire addrgen_pkg::len_t    line_length_i,
  input  wire addrgen_pkg::stride_t line_stride_i,
  input  wire addrgen_pkg::len_t    feat_length_i,
  input  wire addrgen_pkg::stride_t feat_stride_i,
  input  wire addrgen_pkg::len_t    feat_roll_i,
  input  wire logic                 loop_outer_i,
  output addrgen_pkg::addr_t        addr_o,
  output addrgen_pkg::strb_t        strb_o,
  output logic                      first_o,
  output logic                      last_o,
  output logic                      word_update_o,
  output logic                      line_update_o,
  output logic                      feat_update_o,
  output logic                      busy_o,
  output logic                      done_o
);

  addrgen_cfg_if  cfg_bus ();
  addrgen_loop_if loop_bus ();

  addrgen_cfg_regs u_cfg_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .base_addr_i   (base_addr_i),
    .trans_size_i  (trans_size_i),
    .line_length_i (line_length_i),
    .line_stride_i (line_stride_i),
    .feat_length_i (feat_length_i),
    .feat_stride_i (feat_stride_i),
    .feat_roll_i   (feat_roll_i),
    .loop_outer_i  (loop_outer_i),
    .cfg           (cfg_bus.drv)
  );

  addrgen_loop_counters u_loop_counters (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg           (cfg_bus.rd),
    .loop          (loop_bus.cnt),
    .word_update_o (word_update_o),
    .line_update_o (line_update_o),
    .feat_update_o (feat_update_o)
  );

  addrgen_strobe_gen u_strobe_gen (
    .cfg    (cfg_bus.rd),
    .loop   (loop_bus.rd),
    .addr_o (addr_o),
    .strb_o (strb_o)
  );

  addrgen_progress u_progress (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .enable_i (enable_i),
    .cfg      (cfg_bus.rd),
    .loop     (loop_bus.ctl),
    .busy_o   (busy_o),
    .done_o   (done_o)
  );

  // line position markers of the current word
  assign first_o = loop_bus.first_word;
  assign last_o  = loop_bus.last_word;

endmodule

`default_nettype wire
